// File: Makefile
# Verilator build and run for the video output path testbench

VERILATOR ?= verilator
TOP       ?= tbMipiHdmiTop
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tbMipiHdmiTop.sv
// Testbench for the video output path top level
// Clock, reset, random pixel and host stimulus
// Reference model with pixel queue, sticky flag and register copy

`timescale 1ns/100ps

module tbMipiHdmiTop;

//----------------------------------------------------------------------
// Small raster for simulation
//----------------------------------------------------------------------
localparam int HActive			= 8;
localparam int HSync			= 2;
localparam int HBack			= 3;
localparam int HFront			= 2;
localparam int VActive			= 3;
localparam int VSync			= 1;
localparam int VBack			= 1;
localparam int VFront			= 1;
localparam int FifoDepth		= 4;
localparam int StretchCycles	= 5;
localparam int LineCycles		= HSync + HBack + HActive + HFront;		// 15 clocks
localparam int FrameCycles		= LineCycles * (VSync + VBack + VActive + VFront);
localparam int ActivePerFrame	= HActive * VActive;
localparam int WaitLimit		= 4 * FrameCycles;
localparam int Seed				= 20465;

logic					iSCLK, iPushSw, iPllLocked;
videoPkg::pixel_t		iPixel, oHdmiData;
logic					iPixelVd, oPixelFull;
logic					oHdmiVs, oHdmiHs, oHdmiDe;
statusPkg::led_t		oLed;
logic					iCfgReq, oCfgAck, iCfgWe;
statusPkg::cfgAddr_t	iCfgAddr;
statusPkg::cfgData_t	iCfgWrData, oCfgRdData;

// Reference model
videoPkg::pixel_t	expQ [$];		// Pixels accepted, not yet shown
videoPkg::pixel_t	expBlank;
logic				expSticky;
logic				expLedEn;
int					errCount, errAtStart, testCount, testFail;

mipiHdmiTop #(
	.pHActive(HActive),	.pHSync(HSync),		.pHBack(HBack),		.pHFront(HFront),
	.pVActive(VActive),	.pVSync(VSync),		.pVBack(VBack),		.pVFront(VFront),
	.pFifoDepth(FifoDepth),	.pStretchCycles(StretchCycles)
) i_mipiHdmiTop (
	.iSCLK(iSCLK),			.iPushSw(iPushSw),		.iPllLocked(iPllLocked),
	.iPixel(iPixel),		.iPixelVd(iPixelVd),	.oPixelFull(oPixelFull),
	.oHdmiVs(oHdmiVs),		.oHdmiHs(oHdmiHs),		.oHdmiDe(oHdmiDe),
	.oHdmiData(oHdmiData),	.oLed(oLed),
	.iCfgReq(iCfgReq),		.oCfgAck(oCfgAck),		.iCfgWe(iCfgWe),
	.iCfgAddr(iCfgAddr),	.iCfgWrData(iCfgWrData),	.oCfgRdData(oCfgRdData)
);

initial
begin
	iSCLK = 1'b0;
	forever #4 iSCLK = ~iSCLK;		// 125 MHz
end

//----------------------------------------------------------------------
// Reporting
//----------------------------------------------------------------------
task automatic reportMismatch(input string sig, input logic [31:0] got,
	input logic [31:0] exp);
	errCount++;
	$display("Mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
endtask

task automatic reportFailure(input string what);
	errCount++;
	$display("Error at %0t: %s", $time, what);
endtask

task automatic endTest(input string name);
	testCount++;
	if (errCount == errAtStart)
		$display("Test %0d %s: ok", testCount, name);
	else
	begin
		testFail++;
		$display("Test %0d %s: %0d errors", testCount, name, errCount - errAtStart);
	end
	errAtStart = errCount;
endtask

// Expected register contents
function automatic statusPkg::cfgData_t expCtrlWord();
	statusPkg::cfgData_t w;
	w = '0;
	w[statusPkg::CtrlLedEn] = expLedEn;
	return w;
endfunction

function automatic statusPkg::cfgData_t expStatusWord(input logic full);
	statusPkg::cfgData_t w;
	w = '0;
	w[statusPkg::StatOverflow]	= expSticky;
	w[statusPkg::StatLocked]	= 1'b1;		// Lock held high in every test
	w[statusPkg::StatFull]		= full;
	return w;
endfunction

//----------------------------------------------------------------------
// Bounded waits, sampled on the falling edge
//----------------------------------------------------------------------
function automatic logic sigLevel(input string name);
	if (name == "oHdmiVs")			return oHdmiVs;
	else if (name == "oHdmiHs")		return oHdmiHs;
	else if (name == "oPixelFull")	return oPixelFull;
	return oLed[statusPkg::LedFrame];
endfunction

task automatic waitLevel(input string name, input logic level, input int limit);
	int n;
	n = 0;
	@(negedge iSCLK);
	while (sigLevel(name) !== level && n < limit)
	begin
		@(negedge iSCLK);
		n++;
	end
	if (sigLevel(name) !== level)
		reportFailure({"timeout waiting for ", name});
endtask

task automatic waitRise(input string name);
	waitLevel(name, 1'b0, WaitLimit);
	waitLevel(name, 1'b1, WaitLimit);
endtask

//----------------------------------------------------------------------
// Four-phase host access, entered on a falling edge with ack low
//----------------------------------------------------------------------
task automatic cfgAccess(input logic we, input statusPkg::cfgAddr_t addr,
	input statusPkg::cfgData_t wrData, output statusPkg::cfgData_t rdData);
	int n;
	if (oCfgAck !== 1'b0)
		reportFailure("ack high before a new request");
	iCfgWe		= we;
	iCfgAddr	= addr;
	iCfgWrData	= wrData;
	iCfgReq		= 1'b1;
	n = 0;
	do
	begin
		@(negedge iSCLK);
		n++;
	end
	while (oCfgAck !== 1'b1 && n < 20);
	if (oCfgAck !== 1'b1)
		reportFailure("no ack for host request");
	else if (n != 1)
		reportFailure("ack did not follow req by one cycle");
	rdData	= oCfgRdData;		// Valid while ack high
	iCfgReq	= 1'b0;
	n = 0;
	do
	begin
		@(negedge iSCLK);
		n++;
	end
	while (oCfgAck !== 1'b0 && n < 20);
	if (oCfgAck !== 1'b0)
		reportFailure("ack stuck high after req dropped");
	else if (n != 1)
		reportFailure("ack did not fall one cycle after req");
	iCfgWe = 1'b0;
endtask

//----------------------------------------------------------------------
// Raster monitor, starts on a Vs rise
//----------------------------------------------------------------------
task automatic checkRaster(input int frames);
	logic	prevHs, prevVs;
	int		hsRun, vsRun, hsGap, deInLine, deLines, frameCnt;
	waitRise("oHdmiVs");
	prevHs		= oHdmiHs;		// Hs rises with Vs
	prevVs		= 1'b1;
	hsRun		= 1;
	vsRun		= 1;
	hsGap		= 0;
	deInLine	= 0;
	deLines		= 0;
	frameCnt	= 0;
	repeat (frames * FrameCycles)
	begin
		@(negedge iSCLK);
		hsGap++;
		if (oHdmiDe === 1'b1 && oHdmiHs === 1'b1)
			reportFailure("De and Hs high together");
		if (oHdmiDe === 1'b1)
			deInLine++;
		if (oHdmiHs && !prevHs)			// New line
		begin
			if (hsGap != LineCycles)
				reportMismatch("oHdmiHs period", 32'(hsGap), 32'(LineCycles));
			if (deInLine != 0 && deInLine != HActive)
				reportMismatch("oHdmiDe per line", 32'(deInLine), 32'(HActive));
			if (deInLine == HActive)
				deLines++;
			hsGap		= 0;
			deInLine	= 0;
			hsRun		= 1;
		end
		else if (oHdmiHs)
			hsRun++;
		else if (prevHs && hsRun != HSync)
			reportMismatch("oHdmiHs width", 32'(hsRun), 32'(HSync));
		if (oHdmiVs && !prevVs)			// New frame
		begin
			frameCnt++;
			if (deLines != VActive)
				reportMismatch("oHdmiDe lines", 32'(deLines), 32'(VActive));
			deLines	= 0;
			vsRun	= 1;
		end
		else if (oHdmiVs)
			vsRun++;
		else if (prevVs && vsRun != LineCycles)
			reportMismatch("oHdmiVs width", 32'(vsRun), 32'(LineCycles));
		prevHs = oHdmiHs;
		prevVs = oHdmiVs;
	end
	if (frameCnt != frames)
		reportMismatch("oHdmiVs frames", 32'(frameCnt), 32'(frames));
endtask

// One active area against the queue, blank colour once it runs dry
task automatic checkActiveArea();
	int					seen, guard;
	videoPkg::pixel_t	expPix;
	seen	= 0;
	guard	= 0;
	while (seen < ActivePerFrame && guard < WaitLimit)
	begin
		@(negedge iSCLK);
		guard++;
		if (oHdmiDe === 1'b1)
		begin
			if (expQ.size() > 0)
				expPix = expQ.pop_front();
			else
				expPix = expBlank;
			if (oHdmiData !== expPix)
				reportMismatch("oHdmiData", 32'(oHdmiData), 32'(expPix));
			seen++;
		end
		else if (oHdmiData !== '0)
			reportMismatch("oHdmiData", 32'(oHdmiData), 32'd0);		// Blanking
	end
	if (seen < ActivePerFrame)
		reportFailure("timeout waiting for the active area");
endtask

//----------------------------------------------------------------------
// Test sequence
//----------------------------------------------------------------------
initial
begin
	statusPkg::cfgData_t	rd;
	int						n, pushed, guard;
	logic					expFull;
	iPushSw		= 1'b0;
	iPllLocked	= 1'b1;
	iPixel		= '0;
	iPixelVd	= 1'b0;
	iCfgReq		= 1'b0;
	iCfgWe		= 1'b0;
	iCfgAddr	= '0;
	iCfgWrData	= '0;
	errCount	= 0;
	errAtStart	= 0;
	testCount	= 0;
	testFail	= 0;
	expBlank	= '0;
	expSticky	= 1'b0;
	expLedEn	= 1'b1;
	void'($urandom(Seed));

	// 1. Reset state, then loss of lock
	repeat (8) @(negedge iSCLK);
	if (oHdmiHs !== 1'b0)		reportMismatch("oHdmiHs", 32'(oHdmiHs), 32'd0);
	if (oHdmiVs !== 1'b0)		reportMismatch("oHdmiVs", 32'(oHdmiVs), 32'd0);
	if (oHdmiDe !== 1'b0)		reportMismatch("oHdmiDe", 32'(oHdmiDe), 32'd0);
	if (oPixelFull !== 1'b0)	reportMismatch("oPixelFull", 32'(oPixelFull), 32'd0);
	if (oCfgAck !== 1'b0)		reportMismatch("oCfgAck", 32'(oCfgAck), 32'd0);
	if (oLed[4:1] !== 4'b0)		reportMismatch("oLed[4:1]", 32'(oLed[4:1]), 32'd0);
	if (oLed[0] !== 1'b1)		reportMismatch("oLed[0]", 32'(oLed[0]), 32'd1);
	iPushSw = 1'b1;
	waitLevel("oHdmiHs", 1'b1, WaitLimit);
	iPllLocked = 1'b0;			// Drop lock mid sync pulse
	#1;
	if (oHdmiHs !== 1'b0)		reportMismatch("oHdmiHs", 32'(oHdmiHs), 32'd0);
	if (oHdmiVs !== 1'b0)		reportMismatch("oHdmiVs", 32'(oHdmiVs), 32'd0);
	if (oHdmiDe !== 1'b0)		reportMismatch("oHdmiDe", 32'(oHdmiDe), 32'd0);
	@(negedge iSCLK);
	iPllLocked = 1'b1;
	waitLevel("oHdmiHs", 1'b1, WaitLimit);		// Raster restarts
	endTest("reset state");

	// 2. Host handshake and register map
	cfgAccess(1'b0, statusPkg::AddrCtrl, '0, rd);
	if (rd !== expCtrlWord())	reportMismatch("oCfgRdData", 32'(rd), 32'(expCtrlWord()));
	expBlank = videoPkg::pixel_t'($urandom);
	cfgAccess(1'b1, statusPkg::AddrBlank, statusPkg::cfgData_t'(expBlank), rd);
	cfgAccess(1'b0, statusPkg::AddrBlank, '0, rd);
	if (rd !== expBlank)		reportMismatch("oCfgRdData", 32'(rd), 32'(expBlank));
	cfgAccess(1'b1, 2'd3, statusPkg::cfgData_t'($urandom), rd);
	cfgAccess(1'b0, 2'd3, '0, rd);
	if (rd !== '0)				reportMismatch("oCfgRdData", 32'(rd), 32'd0);
	cfgAccess(1'b0, statusPkg::AddrStatus, '0, rd);
	if (rd !== expStatusWord(1'b0))
		reportMismatch("oCfgRdData", 32'(rd), 32'(expStatusWord(1'b0)));
	endTest("host handshake");

	// 3. Raster geometry over two frames
	checkRaster(2);
	endTest("raster geometry");

	// 4. Pixel order and blank fill
	waitLevel("oHdmiVs", 1'b1, WaitLimit);
	waitLevel("oHdmiVs", 1'b0, WaitLimit);
	n		= 1 + int'($urandom % 4);
	pushed	= 0;
	guard	= 0;
	while (pushed < n && guard < 50)
	begin
		if (!oPixelFull)
		begin
			iPixel		= videoPkg::pixel_t'($urandom);
			iPixelVd	= 1'b1;
			expQ.push_back(iPixel);
			pushed++;
		end
		else
			iPixelVd = 1'b0;	// Hold off on full
		@(negedge iSCLK);
		guard++;
	end
	iPixelVd = 1'b0;
	if (pushed < n)
		reportFailure("pixel source stalled on full");
	checkActiveArea();
	endTest("pixel order");

	// 5. Overflow during vertical blanking
	waitRise("oHdmiVs");
	for (int i = 0; i < 7; i++)
	begin
		expFull = (expQ.size() >= FifoDepth);	// No pops in blanking
		if (oPixelFull !== expFull)
			reportMismatch("oPixelFull", 32'(oPixelFull), 32'(expFull));
		iPixel		= videoPkg::pixel_t'($urandom);
		iPixelVd	= 1'b1;
		if (!expFull)
			expQ.push_back(iPixel);
		else
			expSticky = 1'b1;		// Dropped write
		@(negedge iSCLK);
	end
	iPixelVd = 1'b0;
	expFull = (expQ.size() >= FifoDepth);
	waitLevel("oPixelFull", 1'b1, 20);
	cfgAccess(1'b0, statusPkg::AddrStatus, '0, rd);
	if (rd !== expStatusWord(expFull))
		reportMismatch("oCfgRdData", 32'(rd), 32'(expStatusWord(expFull)));
	if (oLed[3] !== (expSticky & expLedEn))
		reportMismatch("oLed[3]", 32'(oLed[3]), 32'(expSticky & expLedEn));
	checkActiveArea();			// Drains the kept pixels
	cfgAccess(1'b1, statusPkg::AddrCtrl, 16'h0003, rd);
	expSticky = 1'b0;
	cfgAccess(1'b0, statusPkg::AddrStatus, '0, rd);
	if (rd !== expStatusWord(1'b0))
		reportMismatch("oCfgRdData", 32'(rd), 32'(expStatusWord(1'b0)));
	if (oLed[3] !== 1'b0)		reportMismatch("oLed[3]", 32'(oLed[3]), 32'd0);
	endTest("overflow flag");

	// 6. LEDs off for a frame of traffic
	expLedEn = 1'b0;
	cfgAccess(1'b1, statusPkg::AddrCtrl, expCtrlWord(), rd);
	cfgAccess(1'b0, statusPkg::AddrCtrl, '0, rd);
	if (rd !== expCtrlWord())	reportMismatch("oCfgRdData", 32'(rd), 32'(expCtrlWord()));
	repeat (FrameCycles)
	begin
		if (oLed[4:1] !== 4'b0)	reportMismatch("oLed[4:1]", 32'(oLed[4:1]), 32'd0);
		if (oLed[0] !== 1'b1)	reportMismatch("oLed[0]", 32'(oLed[0]), 32'd1);
		iPixel		= videoPkg::pixel_t'($urandom);
		iPixelVd	= !oPixelFull && ($urandom % 2 != 0);
		@(negedge iSCLK);
	end
	iPixelVd = 1'b0;
	expLedEn = 1'b1;
	cfgAccess(1'b1, statusPkg::AddrCtrl, expCtrlWord(), rd);
	waitLevel("oLed[4]", 1'b1, WaitLimit);		// Heartbeat back
	endTest("LED enable");

	$display("%0d tests, %0d failed, %0d errors", testCount, testFail, errCount);
	if (errCount == 0)
		$display("TEST PASSED");
	else
		$display("TEST FAILED");
	$finish;
end

endmodule

// File: rtl/boardStatus.sv
// Board status logic
// System reset from push switch and PLL lock
// LED pulse stretchers for stream activity
// Sticky FIFO overflow flag

`timescale 1ns/100ps

module boardStatus #(
	parameter int pStretchCycles = 4000000
)(
	input  logic				iSCLK,
	input  logic				iPushSw,
	input  logic				iPllLocked,
	input  logic				pixelVd,
	input  logic				fifoFull,
	input  logic				overflow,
	input  logic				frameStart,
	output logic				nSysRst,
	output statusPkg::led_t		led,
	statusCfgIf.status			status
);

localparam int StretchW = $clog2(pStretchCycles + 1);

logic		rstRawN;		// Either source pulls reset
logic [1:0]	rstSync;
logic		overflowSticky;
logic [2:0]	stretchEvt, stretchOn;

//----------------------------------------------------------------------
// Reset, asserted at once, released two edges after lock
//----------------------------------------------------------------------
assign rstRawN = iPushSw & iPllLocked;

always_ff @(posedge iSCLK, negedge rstRawN)
begin
	if (!rstRawN)
		rstSync <= 2'b00;
	else
		rstSync <= {rstSync[0], 1'b1};
end

assign nSysRst = rstSync[1];

//----------------------------------------------------------------------
// Sticky overflow, a new drop beats the clear
//----------------------------------------------------------------------
always_ff @(posedge iSCLK, negedge nSysRst)
begin
	if (!nSysRst)						overflowSticky <= 1'b0;
	else if (overflow)					overflowSticky <= 1'b1;
	else if (status.clearOverflow)		overflowSticky <= 1'b0;
end

assign status.overflowSticky	= overflowSticky;
assign status.pllLocked			= iPllLocked;

//----------------------------------------------------------------------
// Pulse stretchers, pixel / full / frame
//----------------------------------------------------------------------
assign stretchEvt = {frameStart, fifoFull, pixelVd};

genvar n;
generate
	for (n = 0; n < 3; n++)
	begin : gStretch
		logic [StretchW-1:0] cnt;

		always_ff @(posedge iSCLK, negedge nSysRst)
		begin
			if (!nSysRst)				cnt <= '0;
			else if (cnt != '0)			cnt <= cnt - 1'b1;		// Runs out first
			else if (stretchEvt[n])		cnt <= StretchW'(pStretchCycles);
		end

		assign stretchOn[n] = (cnt != '0);
	end
endgenerate

// LED map, lock always visible
always_comb
begin
	led = '0;
	led[statusPkg::LedLock] = iPllLocked;
	if (status.ledEnable)
	begin
		led[statusPkg::LedPixel]	= stretchOn[0];
		led[statusPkg::LedFull]		= stretchOn[1];
		led[statusPkg::LedOverflow]	= overflowSticky;	// Level, not a pulse
		led[statusPkg::LedFrame]	= stretchOn[2];
	end
end

endmodule

// File: rtl/cfgRegs.sv
// Host register block
// Four-phase req/ack handshake FSM
// Blank colour, control and status registers

`timescale 1ns/100ps

module cfgRegs (
	input  logic					iSCLK,
	input  logic					nSysRst,
	input  logic					cfgReq,
	input  logic					cfgWe,
	input  statusPkg::cfgAddr_t		cfgAddr,
	input  statusPkg::cfgData_t		cfgWrData,
	input  logic					fifoFull,
	output logic					cfgAck,
	output statusPkg::cfgData_t		cfgRdData,
	output videoPkg::pixel_t		blankColor,
	statusCfgIf.regs				regs
);

typedef enum logic [1:0] {stIdle, stAck, stWaitDrop} hsState_e;

hsState_e				state;
logic					access;		// Request taken this edge
statusPkg::cfgData_t	statusWord, ctrlWord;

assign access = (state == stIdle) && cfgReq;

//----------------------------------------------------------------------
// Handshake FSM
//----------------------------------------------------------------------
always_ff @(posedge iSCLK, negedge nSysRst)
begin
	if (!nSysRst)
		state <= stIdle;
	else
	begin
		case (state)
			stIdle:		if (cfgReq)		state <= stAck;
			stAck:		state <= cfgReq ? stWaitDrop : stIdle;	// Quick drop allowed
			stWaitDrop:	if (!cfgReq)	state <= stIdle;
			default:	state <= stIdle;
		endcase
	end
end

assign cfgAck = (state != stIdle);		// Straight from state flops

//----------------------------------------------------------------------
// Register writes
//----------------------------------------------------------------------
always_ff @(posedge iSCLK, negedge nSysRst)
begin
	if (!nSysRst)
	begin
		blankColor			<= '0;
		regs.ledEnable		<= 1'b1;	// LEDs on out of reset
		regs.clearOverflow	<= 1'b0;
	end
	else
	begin
		regs.clearOverflow <= 1'b0;
		if (access && cfgWe)
		begin
			case (cfgAddr)
				statusPkg::AddrBlank:	blankColor <= videoPkg::pixel_t'(cfgWrData);
				statusPkg::AddrCtrl:
				begin
					regs.ledEnable		<= cfgWrData[statusPkg::CtrlLedEn];
					regs.clearOverflow	<= cfgWrData[statusPkg::CtrlClrOvf];
				end
				default:	;			// Status and addr 3 ignore writes
			endcase
		end
	end
end

//----------------------------------------------------------------------
// Read path, captured at the access
//----------------------------------------------------------------------
always_comb
begin
	statusWord = '0;
	statusWord[statusPkg::StatOverflow]	= regs.overflowSticky;
	statusWord[statusPkg::StatLocked]	= regs.pllLocked;
	statusWord[statusPkg::StatFull]		= fifoFull;
	ctrlWord = '0;
	ctrlWord[statusPkg::CtrlLedEn]		= regs.ledEnable;	// Clear bit reads 0
end

always_ff @(posedge iSCLK)
begin
	if (access)
	begin
		case (cfgAddr)
			statusPkg::AddrBlank:	cfgRdData <= statusPkg::cfgData_t'(blankColor);
			statusPkg::AddrCtrl:	cfgRdData <= ctrlWord;
			statusPkg::AddrStatus:	cfgRdData <= statusWord;
			default:				cfgRdData <= '0;
		endcase
	end
end

apAckNeedsReq: assert property (@(posedge iSCLK) disable iff (!nSysRst)
	$rose(cfgAck) |-> $past(cfgReq));

endmodule

// File: rtl/hdmiTimingGen.sv
// Raster timing generator for the HDMI transmitter
// Horizontal and vertical counters with line phase decode
// Registered syncs, data enable and pixel data
// Pops the FIFO in active video, blank colour when it runs dry

`timescale 1ns/100ps

module hdmiTimingGen #(
	parameter int pHActive	= videoPkg::DefHActive,
	parameter int pHSync	= videoPkg::DefHSync,
	parameter int pHBack	= videoPkg::DefHBack,
	parameter int pHFront	= videoPkg::DefHFront,
	parameter int pVActive	= videoPkg::DefVActive,
	parameter int pVSync	= videoPkg::DefVSync,
	parameter int pVBack	= videoPkg::DefVBack,
	parameter int pVFront	= videoPkg::DefVFront
)(
	input  logic				iSCLK,
	input  logic				nSysRst,
	input  videoPkg::pixel_t	headPixel,
	input  logic				empty,
	input  videoPkg::pixel_t	blankColor,
	output logic				pop,
	output logic				frameStart,
	output logic				hdmiVs,
	output logic				hdmiHs,
	output logic				hdmiDe,
	output videoPkg::pixel_t	hdmiData
);

typedef enum logic [1:0] {phSync, phBack, phActive, phFront} linePhase_e;

// Phase boundaries, counted from the sync start
localparam videoPkg::hCount_t HBackStart	= videoPkg::hCount_t'(pHSync);
localparam videoPkg::hCount_t HActStart		= videoPkg::hCount_t'(pHSync + pHBack);
localparam videoPkg::hCount_t HFrontStart	= videoPkg::hCount_t'(pHSync + pHBack + pHActive);
localparam videoPkg::hCount_t HLast			=
	videoPkg::hCount_t'(pHSync + pHBack + pHActive + pHFront - 1);
localparam videoPkg::vCount_t VBackStart	= videoPkg::vCount_t'(pVSync);
localparam videoPkg::vCount_t VActStart		= videoPkg::vCount_t'(pVSync + pVBack);
localparam videoPkg::vCount_t VFrontStart	= videoPkg::vCount_t'(pVSync + pVBack + pVActive);
localparam videoPkg::vCount_t VLast			=
	videoPkg::vCount_t'(pVSync + pVBack + pVActive + pVFront - 1);

videoPkg::hCount_t	hCnt;
videoPkg::vCount_t	vCnt;
linePhase_e			hPhase, vPhase;
logic				deNext;

//----------------------------------------------------------------------
// Raster counters, free running from reset
//----------------------------------------------------------------------
always_ff @(posedge iSCLK, negedge nSysRst)
begin
	if (!nSysRst)
	begin
		hCnt <= '0;
		vCnt <= '0;
	end
	else if (hCnt == HLast)
	begin
		hCnt <= '0;
		vCnt <= (vCnt == VLast) ? '0 : vCnt + 1'b1;		// Next line or frame wrap
	end
	else
		hCnt <= hCnt + 1'b1;
end

// Phase decode, same enum for both axes
always_comb
begin
	if (hCnt < HBackStart)			hPhase = phSync;
	else if (hCnt < HActStart)		hPhase = phBack;
	else if (hCnt < HFrontStart)	hPhase = phActive;
	else							hPhase = phFront;

	if (vCnt < VBackStart)			vPhase = phSync;
	else if (vCnt < VActStart)		vPhase = phBack;
	else if (vCnt < VFrontStart)	vPhase = phActive;
	else							vPhase = phFront;
end

assign deNext	= (hPhase == phActive) && (vPhase == phActive);
assign pop		= deNext && !empty;		// Head leaves at this edge

//----------------------------------------------------------------------
// Output registers, one cycle behind the counters
//----------------------------------------------------------------------
always_ff @(posedge iSCLK, negedge nSysRst)
begin
	if (!nSysRst)
	begin
		hdmiHs		<= 1'b0;
		hdmiVs		<= 1'b0;
		hdmiDe		<= 1'b0;
		hdmiData	<= '0;
		frameStart	<= 1'b0;
	end
	else
	begin
		hdmiHs		<= (hPhase == phSync);
		hdmiVs		<= (vPhase == phSync);		// Whole lines
		hdmiDe		<= deNext;
		frameStart	<= (hCnt == '0) && (vCnt == '0);
		if (!deNext)
			hdmiData <= '0;						// Zero in blanking
		else
			hdmiData <= empty ? blankColor : headPixel;
	end
end

apDeNotHs: assert property (@(posedge iSCLK) disable iff (!nSysRst) !(hdmiDe && hdmiHs));

endmodule

// File: rtl/mipiHdmiTop.sv
// Video output path top level
// Pixel FIFO, HDMI raster generator, board status, host registers

`timescale 1ns/100ps

module mipiHdmiTop #(
	parameter int pHActive			= videoPkg::DefHActive,
	parameter int pHSync			= videoPkg::DefHSync,
	parameter int pHBack			= videoPkg::DefHBack,
	parameter int pHFront			= videoPkg::DefHFront,
	parameter int pVActive			= videoPkg::DefVActive,
	parameter int pVSync			= videoPkg::DefVSync,
	parameter int pVBack			= videoPkg::DefVBack,
	parameter int pVFront			= videoPkg::DefVFront,
	parameter int pFifoDepth		= 16,
	parameter int pStretchCycles	= 4000000		// About 40 ms at 100 MHz
)(
	input  logic					iSCLK,
	input  logic					iPushSw,		// Active low
	input  logic					iPllLocked,
	// Pixel stream in
	input  videoPkg::pixel_t		iPixel,
	input  logic					iPixelVd,
	output logic					oPixelFull,
	// HDMI transmitter
	output logic					oHdmiVs,
	output logic					oHdmiHs,
	output logic					oHdmiDe,
	output videoPkg::pixel_t		oHdmiData,
	output statusPkg::led_t			oLed,
	// Host port
	input  logic					iCfgReq,
	output logic					oCfgAck,
	input  logic					iCfgWe,
	input  statusPkg::cfgAddr_t		iCfgAddr,
	input  statusPkg::cfgData_t		iCfgWrData,
	output statusPkg::cfgData_t		oCfgRdData
);

logic				nSysRst;
logic				fifoEmpty, fifoPop, fifoOverflow, frameStart;
videoPkg::pixel_t	headPixel, blankColor;

statusCfgIf cfgIf ();

//----------------------------------------------------------------------
// Blocks
//----------------------------------------------------------------------
boardStatus #(.pStretchCycles(pStretchCycles)) uBoardStatus (
	.iSCLK(iSCLK),				.iPushSw(iPushSw),			.iPllLocked(iPllLocked),
	.pixelVd(iPixelVd),			.fifoFull(oPixelFull),		.overflow(fifoOverflow),
	.frameStart(frameStart),	.nSysRst(nSysRst),			.led(oLed),
	.status(cfgIf.status)
);

cfgRegs uCfgRegs (
	.iSCLK(iSCLK),				.nSysRst(nSysRst),
	.cfgReq(iCfgReq),			.cfgWe(iCfgWe),
	.cfgAddr(iCfgAddr),			.cfgWrData(iCfgWrData),
	.fifoFull(oPixelFull),		.cfgAck(oCfgAck),
	.cfgRdData(oCfgRdData),		.blankColor(blankColor),
	.regs(cfgIf.regs)
);

pixelFifo #(.pFifoDepth(pFifoDepth)) uPixelFifo (
	.iSCLK(iSCLK),				.nSysRst(nSysRst),
	.wrPixel(iPixel),			.wrValid(iPixelVd),			.pop(fifoPop),
	.headPixel(headPixel),		.full(oPixelFull),			.empty(fifoEmpty),
	.overflow(fifoOverflow)
);

hdmiTimingGen #(
	.pHActive(pHActive),	.pHSync(pHSync),	.pHBack(pHBack),	.pHFront(pHFront),
	.pVActive(pVActive),	.pVSync(pVSync),	.pVBack(pVBack),	.pVFront(pVFront)
) uHdmiTimingGen (
	.iSCLK(iSCLK),				.nSysRst(nSysRst),
	.headPixel(headPixel),		.empty(fifoEmpty),			.blankColor(blankColor),
	.pop(fifoPop),				.frameStart(frameStart),
	.hdmiVs(oHdmiVs),			.hdmiHs(oHdmiHs),
	.hdmiDe(oHdmiDe),			.hdmiData(oHdmiData)
);

endmodule

// File: rtl/pixelFifo.sv
// Pixel FIFO between the input stream and the raster generator
// Circular buffer, occupancy counter, registered full and empty
// Dropped writes flagged one cycle each

`timescale 1ns/100ps

module pixelFifo #(
	parameter int pFifoDepth = 16
)(
	input  logic				iSCLK,
	input  logic				nSysRst,
	input  videoPkg::pixel_t	wrPixel,
	input  logic				wrValid,
	input  logic				pop,
	output videoPkg::pixel_t	headPixel,
	output logic				full,
	output logic				empty,
	output logic				overflow
);

localparam int PtrW = (pFifoDepth > 1) ? $clog2(pFifoDepth) : 1;
localparam int CntW = $clog2(pFifoDepth + 1);

videoPkg::pixel_t	mem [pFifoDepth];		// Pixel storage
logic [PtrW-1:0]	wrPtr, rdPtr;
logic [CntW-1:0]	count, countNext;
logic				doWr, doRd;

assign doWr = wrValid && !full;			// Full write gets dropped
assign doRd = pop && !empty;

always_comb
begin
	countNext = count;
	if (doWr && !doRd)
		countNext = count + 1'b1;
	else if (doRd && !doWr)
		countNext = count - 1'b1;
end

//----------------------------------------------------------------------
// Pointers, count and flags
//----------------------------------------------------------------------
always_ff @(posedge iSCLK, negedge nSysRst)
begin
	if (!nSysRst)
	begin
		wrPtr		<= '0;
		rdPtr		<= '0;
		count		<= '0;
		full		<= 1'b0;
		empty		<= 1'b1;
		overflow	<= 1'b0;
	end
	else
	begin
		if (doWr)	wrPtr <= (wrPtr == PtrW'(pFifoDepth - 1)) ? '0 : wrPtr + 1'b1;
		if (doRd)	rdPtr <= (rdPtr == PtrW'(pFifoDepth - 1)) ? '0 : rdPtr + 1'b1;
		count		<= countNext;
		full		<= (countNext == CntW'(pFifoDepth));	// Flags lag one cycle
		empty		<= (countNext == '0);
		overflow	<= wrValid && full;						// Lost pixel
	end
end

// Storage has no reset
always_ff @(posedge iSCLK)
begin
	if (doWr)
		mem[wrPtr] <= wrPixel;
end

assign headPixel = mem[rdPtr];		// Show-ahead read

// Raster side must respect empty
apPopNotEmpty: assert property (@(posedge iSCLK) disable iff (!nSysRst) pop |-> !empty);
apCountLimit: assert property (@(posedge iSCLK) disable iff (!nSysRst)
	count <= CntW'(pFifoDepth));

endmodule

// File: rtl/statusCfgIf.sv
// Link between the register block and board status
// Control toward status, flags back toward the registers

`timescale 1ns/100ps

interface statusCfgIf;

	logic clearOverflow;	// One cycle pulse from a control write
	logic ledEnable;		// Activity LEDs on
	logic overflowSticky;	// Held until cleared
	logic pllLocked;		// Lock as seen by status logic

	// Register block side
	modport regs (
		output	clearOverflow,
		output	ledEnable,
		input	overflowSticky,
		input	pllLocked
	);

	// Board status side
	modport status (
		input	clearOverflow,
		input	ledEnable,
		output	overflowSticky,
		output	pllLocked
	);

endinterface

// File: rtl/statusPkg.sv
// Board status and host register definitions
// Address, data and LED types, register map and bit positions

package statusPkg;

	typedef logic [1:0]  cfgAddr_t;
	typedef logic [15:0] cfgData_t;
	typedef logic [4:0]  led_t;

	//----------------------------------------------------------------------
	// Register map, address 3 reads zero
	//----------------------------------------------------------------------
	localparam cfgAddr_t AddrBlank	= 2'd0;		// Blank colour, RW
	localparam cfgAddr_t AddrCtrl	= 2'd1;		// Control, RW
	localparam cfgAddr_t AddrStatus	= 2'd2;		// Status, RO

	localparam int CtrlClrOvf	= 0;	// W1C overflow, reads 0
	localparam int CtrlLedEn	= 1;	// LED bits 1..4 enable
	localparam int StatOverflow	= 0;	// Sticky FIFO overflow
	localparam int StatLocked	= 1;	// PLL lock
	localparam int StatFull		= 2;	// FIFO full right now

	// LED positions
	localparam int LedLock		= 0;
	localparam int LedPixel		= 1;
	localparam int LedFull		= 2;
	localparam int LedOverflow	= 3;
	localparam int LedFrame		= 4;

endpackage

// File: rtl/videoPkg.sv
// Video path definitions
// Pixel and raster counter types
// Default 1080p60 raster timing

package videoPkg;

	//----------------------------------------------------------------------
	// Types
	//----------------------------------------------------------------------
	typedef logic [15:0] pixel_t;		// YCbCr 4:2:2, Y in upper byte
	typedef logic [11:0] hCount_t;		// Up to 4095 clocks per line
	typedef logic [10:0] vCount_t;		// Up to 2047 lines per frame

	//----------------------------------------------------------------------
	// 1080p60 defaults, 148.5 MHz pixel clock
	//----------------------------------------------------------------------
	localparam int DefHActive	= 1920;
	localparam int DefHSync		= 44;
	localparam int DefHBack		= 148;
	localparam int DefHFront	= 88;	// 2200 clocks per line

	localparam int DefVActive	= 1080;
	localparam int DefVSync		= 5;
	localparam int DefVBack		= 36;
	localparam int DefVFront	= 4;	// 1125 lines per frame

endpackage

// File: sources.f
rtl/videoPkg.sv
rtl/statusPkg.sv
rtl/statusCfgIf.sv
rtl/pixelFifo.sv
rtl/hdmiTimingGen.sv
rtl/boardStatus.sv
rtl/cfgRegs.sv
rtl/mipiHdmiTop.sv
dv/tbMipiHdmiTop.sv
